/* scroll_layer.f */
src/scroll_pkg.sv
src/scroll_ctrl.sv
src/tile_ram.sv
src/scroll_scan.sv
src/tile_fetch.sv
src/pixel_shifter.sv
src/scroll_layer.sv
verif/scroll_layer_asserts.sv
verif/tb_scroll_layer.sv

/* verif/tb_scroll_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scroll_layer;

    localparam int OP_READ = 0, OP_FILL = 1, OP_RANDRW = 2, OP_LINE = 3, OP_SCROLL = 4;
    localparam int OP_LINE_WR = 5, N_OPS = 15;

    typedef struct {
        int          op;
        logic [12:0] addr;
        logic [31:0] data;      // mask, count, scroll pair or line number
        logic [31:0] exp_val;
    } step_t;

    logic clk = 1'b0, rst_n = 1'b0;
    logic [12:0] awaddr = '0, araddr = '0;
    logic [31:0] wdata = '0;
    logic awvalid = 1'b0, wvalid = 1'b0, bready = 1'b0, arvalid = 1'b0, rready = 1'b0;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic [31:0] rdata;
    logic [8:0] h_cnt = '0, v_cnt = '0, line_v = '0;
    logic [8:0] sx = '0, sy = '0;       // scroll values as last written
    logic [14:0] rom_addr, last_rom = '0;
    logic [23:0] rom_data;
    scroll_pkg::pixel_t pixel;
    logic [15:0] shadow [1024];         // mirror of the tile map
    logic [15:0] lfsr = 16'd30425;
    step_t table_q [N_OPS];
    bit line_req = 0, line_on = 0;
    int lines_done = 0, cycles = 0, limit = 0;

    scroll_layer i_dut (.*);

    function automatic logic [23:0] rom_word(input logic [14:0] a);
        return ({9'd0, a} * 24'd40503) ^ {a, a[14:6]};  // arbitrary mixing
    endfunction

    function automatic logic [14:0] rom_index(input logic [15:0] t, input logic [8:0] x,
                                              input logic [8:0] y);
        return {t[15:14], t[7:0], x[3] ^ t[12], y[3:0] ^ {4{t[13]}}};
    endfunction

    // colour from planes x,y,z at the column, then palette and window
    function automatic logic [6:0] ref_pixel(input logic [8:0] x, input logic [8:0] y);
        logic [15:0] t;
        logic [23:0] w;
        logic [2:0] b;
        t = shadow[{x[8:4], y[8:4]}];
        w = rom_word(rom_index(t, x, y));
        b = t[12] ? x[2:0] : 3'd7 - x[2:0];    // hflip puts column 0 at bit 0
        return {w[b], w[8+b], w[16+b], t[10:8], t[11]};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    assign rom_data = rom_word(rom_addr);   // combinational rom

    initial forever #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp, got);
        $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [12:0] addr, input logic [31:0] data);
        logic [31:0] hold;
        int lat;
        lat = 1;                            // first cycle after acceptance
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do next_cycle; while (!awready);
        next_cycle;                         // handshake edge
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) begin
            next_cycle;
            lat++;
        end
        assert (lat <= 6) else report_mismatch("bvalid latency", 6, lat);
        get_bits(2, hold);
        repeat (hold) next_cycle;           // back-pressure
        bready = 1'b1;
        next_cycle;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [12:0] addr, output logic [31:0] data);
        logic [31:0] hold;
        araddr = addr;
        arvalid = 1'b1;
        do next_cycle; while (!arready);
        next_cycle;
        arvalid = 1'b0;
        while (!rvalid) next_cycle;
        get_bits(2, hold);
        repeat (hold) next_cycle;
        data = rdata;
        rready = 1'b1;
        next_cycle;
        rready = 1'b0;
    endtask

    task automatic map_write(input logic [9:0] idx, input logic [31:0] data);
        axi_write({1'b0, idx, 2'b00}, data);
        shadow[idx] = data[15:0];
    endtask

    task automatic run_line(input logic [8:0] v);
        int n;
        n = lines_done;
        line_v = v;
        line_req = 1;
        wait (lines_done != n);
    endtask

    // beam driver and pixel checks, values of the cycle that just ended
    always @(posedge clk) begin
        logic [8:0]  hs;        // position the fetch saw in that cycle
        logic [8:0]  vs;
        logic [14:0] exp_rom;
        #1;
        hs = h_cnt + 9'd13 + sx;
        vs = v_cnt + sy;
        if (line_on && h_cnt >= 24) begin
            assert (pixel == ref_pixel(h_cnt + sx, v_cnt + sy))
                else report_mismatch("pixel", ref_pixel(h_cnt + sx, v_cnt + sy), pixel);
            if (rom_addr != last_rom) begin
                exp_rom = rom_index(shadow[{hs[8:4], vs[8:4]}], hs, vs);
                assert (rom_addr == exp_rom)
                    else report_mismatch("rom_addr", exp_rom, rom_addr);
            end
        end
        last_rom = rom_addr;
        if (h_cnt == 9'd511) begin
            if (line_on) lines_done++;
            line_on = line_req;
            line_req = 0;
            v_cnt = line_v;
        end
        h_cnt = h_cnt + 1;
    end

    always @(posedge clk) begin
        cycles++;
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("A bus protocol assertion failed before %0t", $time);
            $display("Test failed");
            $fatal(1, "assertion");
        end else if (limit > 0 && cycles > limit) begin
            $display("Run stopped, the tests did not finish within %0d cycles", limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] d, r;
        int len;
        table_q[0]  = '{OP_READ, 13'h1000, 0, 0};
        table_q[1]  = '{OP_READ, 13'h1004, 0, 0};
        table_q[2]  = '{OP_FILL, 0, 32'hcfff, 0};       // no flips
        table_q[3]  = '{OP_RANDRW, 0, 12, 0};
        table_q[4]  = '{OP_READ, 13'h1008, 0, 0};       // unmapped
        table_q[5]  = '{OP_LINE, 0, 5, 0};
        table_q[6]  = '{OP_LINE, 0, 100, 0};
        table_q[7]  = '{OP_SCROLL, 0, {9'h1f3, 9'h0a7}, 0};
        table_q[8]  = '{OP_LINE, 0, 9'h180, 0};         // vs wraps
        table_q[9]  = '{OP_SCROLL, 0, {9'h009, 9'h1ff}, 0};
        table_q[10] = '{OP_LINE, 0, 37, 0};
        table_q[11] = '{OP_FILL, 0, 32'hffff, 0};       // random flips
        table_q[12] = '{OP_LINE, 0, 3, 0};
        table_q[13] = '{OP_LINE_WR, {1'b0, 5'd3, 5'd20, 2'b00}, 200, 32'hdead3c5a};
        table_q[14] = '{OP_READ, {1'b0, 5'd3, 5'd20, 2'b00}, 0, 32'h00003c5a};
        len = 0;
        foreach (table_q[i]) begin
            case (table_q[i].op)
                OP_FILL:   len += 1024 * 14;
                OP_RANDRW: len += table_q[i].data * 30;
                OP_LINE, OP_LINE_WR: len += 1100;
                default:   len += 40;
            endcase
        end
        limit = 20 * len;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        assert (!awready && !wready && !arready && !bvalid && !rvalid)
            else report_mismatch("axi outputs after reset", 0,
                                 {awready, wready, arready, bvalid, rvalid});
        foreach (table_q[i]) begin
            case (table_q[i].op)
                OP_READ: begin
                    axi_read(table_q[i].addr, r);
                    assert (r == table_q[i].exp_val)
                        else report_mismatch("rdata", table_q[i].exp_val, r);
                end
                OP_FILL: for (int k = 0; k < 1024; k++) begin
                    get_bits(32, d);
                    map_write(10'(k), d & table_q[i].data);
                end
                OP_RANDRW: repeat (table_q[i].data) begin
                    get_bits(10, r);
                    get_bits(32, d);
                    map_write(r[9:0], d);
                    axi_read({1'b0, r[9:0], 2'b00}, r);
                    assert (r == {16'h0, d[15:0]})
                        else report_mismatch("rdata", {16'h0, d[15:0]}, r);
                end
                OP_SCROLL: begin
                    axi_write(13'h1000, {23'h7abcd, table_q[i].data[17:9]});
                    axi_write(13'h1004, table_q[i].data[8:0]);
                    sx = table_q[i].data[17:9];
                    sy = table_q[i].data[8:0];
                    axi_read(13'h1000, r);
                    assert (r == sx) else report_mismatch("scroll_x", sx, r);
                end
                OP_LINE: run_line(table_q[i].data[8:0]);
                default: fork   // cpu write while the line is checked
                    run_line(table_q[i].data[8:0]);
                    begin
                        wait (line_on);
                        repeat (150) next_cycle;
                        map_write(table_q[i].addr[11:2], table_q[i].exp_val);
                    end
                join
            endcase
        end
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* verif/scroll_layer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_layer_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        wready,
    input logic        arready,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready
);

    int fail_count = 0;    // failed assertions so far

    // responses held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end
    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else begin
            fail_count++;
            $error("rdata changed while waiting");
        end
    a_resp_okay: assert property (@(posedge clk)
        bresp == 2'b00 && rresp == 2'b00)
        else begin
            fail_count++;
            $error("non-okay response");
        end
    a_reset_low: assert property (@(posedge clk)
        !rst_n |=> !(awready || wready || arready || bvalid || rvalid))
        else begin
            fail_count++;
            $error("axi outputs high after reset");
        end

endmodule

bind scroll_layer scroll_layer_asserts i_asserts (.*);

`default_nettype wire

/* src/scroll_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_layer #(
    parameter int map_aw   = 10,
    parameter int h_offset = 13
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [12:0]        awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [12:0]        araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    input  logic [8:0]         h_cnt,
    input  logic [8:0]         v_cnt,
    output logic [14:0]        rom_addr,   // gfx rom, data back next cycle
    input  logic [23:0]        rom_data,
    output scroll_pkg::pixel_t pixel
);

    scroll_pkg::scan_pos_t   pos;
    scroll_pkg::tile_entry_t ram_q, ram_wdata, tile_attr;
    logic [map_aw-1:0]       ram_addr;
    logic [9:0]              scan_index;
    logic [2:0]              phase;
    logic                    ram_we;
    logic [8:0]              scroll_x, scroll_y;

    scroll_ctrl #(.map_aw(map_aw)) i_ctrl (
        .clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .phase, .scan_index, .ram_q, .ram_addr, .ram_we,
        .ram_wdata, .scroll_x, .scroll_y
    );

    tile_ram #(.map_aw(map_aw)) i_ram (
        .clk, .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .q(ram_q)
    );

    scroll_scan #(.h_offset(h_offset)) i_scan (
        .h_cnt, .v_cnt, .scroll_x, .scroll_y, .pos, .scan_index, .phase
    );

    tile_fetch i_fetch (
        .clk, .rst_n, .phase, .pos, .ram_q, .rom_addr, .attr(tile_attr)
    );

    pixel_shifter i_shift (
        .clk, .rst_n, .phase, .rom_data, .attr(tile_attr), .pixel
    );

endmodule

`default_nettype wire

/* src/pixel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_shifter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [2:0]              phase,
    input  logic [23:0]             rom_data,
    input  scroll_pkg::tile_entry_t attr,
    output scroll_pkg::pixel_t      pixel
);

    logic [23:0]        row_hold;        // row of the tile behind
    logic [7:0]         px, py, pz;      // bit planes
    logic               hflip;
    logic [2:0]         palette;
    logic               window;
    scroll_pkg::pixel_t colour_q;
    scroll_pkg::pixel_t align_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_hold <= '0;
            {pz, py, px} <= '0;
            hflip    <= 1'b0;
            palette  <= '0;
            window   <= 1'b0;
            colour_q <= '0;
            align_q  <= '0;
            pixel    <= '0;
        end else begin
            if (phase == 3'd2) begin
                row_hold     <= rom_data;
                {pz, py, px} <= row_hold;  // planes z, y, x from the top
                hflip        <= attr.hflip;
                palette      <= attr.palette;
                window       <= attr.window;
            end else if (hflip) begin      // mirrored, bit 0 leaves first
                px <= {1'b0, px[7:1]};
                py <= {1'b0, py[7:1]};
                pz <= {1'b0, pz[7:1]};
            end else begin
                px <= {px[6:0], 1'b0};
                py <= {py[6:0], 1'b0};
                pz <= {pz[6:0], 1'b0};
            end
            colour_q.colour  <= hflip ? {px[0], py[0], pz[0]} : {px[7], py[7], pz[7]};
            colour_q.palette <= palette;
            colour_q.window  <= window;
            align_q <= colour_q;           // two stages to land on h_offset
            pixel   <= align_q;
        end
    end

endmodule

`default_nettype wire

/* src/tile_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [2:0]              phase,
    input  scroll_pkg::scan_pos_t   pos,
    input  scroll_pkg::tile_entry_t ram_q,
    output logic [14:0]             rom_addr,
    output scroll_pkg::tile_entry_t attr
);

    scroll_pkg::tile_entry_t cur_tile;   // tile whose row is being read now

    // ram_q at phase 1 is the word addressed at phase 0 of this group
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_addr <= '0;
            cur_tile <= '0;
            attr     <= '0;
        end else if (phase == 3'd1) begin
            attr     <= cur_tile;         // follows its row one tile later
            cur_tile <= ram_q;
            rom_addr <= {ram_q.code_hi, ram_q.code,
                         pos.hs[3] ^ ram_q.hflip,          // left or right half
                         pos.vs[3:0] ^ {4{ram_q.vflip}}};  // row in tile
        end
    end

endmodule

`default_nettype wire

/* src/scroll_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_scan #(
    parameter int h_offset = 13
) (
    input  logic [8:0]            h_cnt,
    input  logic [8:0]            v_cnt,
    input  logic [8:0]            scroll_x,
    input  logic [8:0]            scroll_y,
    output scroll_pkg::scan_pos_t pos,
    output logic [9:0]            scan_index,
    output logic [2:0]            phase
);

    logic [8:0] hs;
    logic [8:0] vs;

    // beam runs h_offset pixels ahead to cover the fetch pipeline
    always_comb begin
        hs = h_cnt + 9'(h_offset) + scroll_x;  // wraps at 512
        vs = v_cnt + scroll_y;
    end

    always_comb begin
        pos.pad = 2'b00;
        pos.hs  = hs;
        pos.vs  = vs;
    end

    // column-major map, 16 pixel tiles
    assign scan_index = {hs[8:4], vs[8:4]};
    assign phase      = hs[2:0];      // pixel within the 8-pixel group

endmodule

`default_nettype wire

/* src/tile_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// map cells, one word each
module tile_ram #(
    parameter int map_aw = 10
) (
    input  logic                    clk,
    input  logic [map_aw-1:0]       addr,
    input  logic                    we,
    input  scroll_pkg::tile_entry_t wdata,
    output scroll_pkg::tile_entry_t q
);

    scroll_pkg::tile_entry_t mem [2**map_aw];

    // single port, registered read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];    // old word on a write cycle
    end

endmodule

`default_nettype wire

/* src/scroll_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_ctrl #(
    parameter int map_aw = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [12:0]             awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [12:0]             araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic [2:0]              phase,      // scan pixel phase, hs[2:0]
    input  logic [map_aw-1:0]       scan_index,
    input  scroll_pkg::tile_entry_t ram_q,
    output logic [map_aw-1:0]       ram_addr,
    output logic                    ram_we,
    output scroll_pkg::tile_entry_t ram_wdata,
    output logic [8:0]              scroll_x,
    output logic [8:0]              scroll_y
);

    scroll_pkg::axi_state_e  state;
    scroll_pkg::reg_sel_e    sel;        // target of the request taken now
    scroll_pkg::tile_entry_t cpu_data;
    logic [map_aw-1:0]       cpu_index;  // map word of the pending access
    logic                    is_write;
    logic                    rd_cap;     // ram output holds cpu read data
    logic                    cpu_slot;

    function automatic scroll_pkg::reg_sel_e decode(input logic [12:0] addr);
        scroll_pkg::reg_sel_e s;
        if ((addr & 13'h1000) == scroll_pkg::RAM_BASE)
            s = scroll_pkg::SEL_RAM;
        else if (addr == scroll_pkg::SCROLL_X_ADDR)
            s = scroll_pkg::SEL_SCROLL_X;
        else if (addr == scroll_pkg::SCROLL_Y_ADDR)
            s = scroll_pkg::SEL_SCROLL_Y;
        else
            s = scroll_pkg::SEL_NONE;   // reads back zero
        return s;
    endfunction

    assign sel       = decode(awready ? awaddr : araddr);
    assign cpu_slot  = (state == scroll_pkg::WAIT_SLOT) && phase[2]; // scan-free half
    assign ram_addr  = cpu_slot ? cpu_index : scan_index;
    assign ram_we    = cpu_slot && is_write;
    assign ram_wdata = cpu_data;
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= scroll_pkg::IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            rd_cap   <= 1'b0;
            scroll_x <= '0;
            scroll_y <= '0;
        end else begin
            case (state)
                scroll_pkg::IDLE: begin
                    if (awready) begin              // aw and w handshake together
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        if (sel == scroll_pkg::SEL_RAM) begin
                            state <= scroll_pkg::WAIT_SLOT;
                        end else begin
                            if (sel == scroll_pkg::SEL_SCROLL_X) scroll_x <= wdata[8:0];
                            if (sel == scroll_pkg::SEL_SCROLL_Y) scroll_y <= wdata[8:0];
                            bvalid <= 1'b1;
                            state  <= scroll_pkg::RESP;
                        end
                    end else if (arready) begin
                        arready <= 1'b0;
                        if (sel == scroll_pkg::SEL_RAM) begin
                            state <= scroll_pkg::WAIT_SLOT;
                        end else begin
                            rvalid <= 1'b1;         // register data set below
                            state  <= scroll_pkg::RESP;
                        end
                    end else if (awvalid && wvalid) begin  // write wins a tie
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                scroll_pkg::WAIT_SLOT: begin
                    if (phase[2]) begin
                        bvalid <= is_write;
                        rd_cap <= !is_write;        // q valid next cycle
                        state  <= scroll_pkg::RESP;
                    end
                end
                scroll_pkg::RESP: begin
                    if (rd_cap) begin
                        rd_cap <= 1'b0;
                        rvalid <= 1'b1;
                    end
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= scroll_pkg::IDLE;
                    end
                    if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state  <= scroll_pkg::IDLE;
                    end
                end
                default: state <= scroll_pkg::IDLE;
            endcase
        end
    end

    // request payload and read data
    always_ff @(posedge clk) begin
        if (state == scroll_pkg::IDLE && awready) begin
            is_write  <= 1'b1;
            cpu_index <= awaddr[map_aw+1:2];
            cpu_data  <= wdata[15:0];              // full word, strobes ignored
        end else if (state == scroll_pkg::IDLE && arready) begin
            is_write  <= 1'b0;
            cpu_index <= araddr[map_aw+1:2];
            case (sel)
                scroll_pkg::SEL_SCROLL_X: rdata <= {23'd0, scroll_x};
                scroll_pkg::SEL_SCROLL_Y: rdata <= {23'd0, scroll_y};
                default:                  rdata <= '0;
            endcase
        end
        if (rd_cap) rdata <= {16'h0000, ram_q};   // zero extended map word
    end

endmodule

`default_nettype wire

/* src/scroll_pkg.sv */
`default_nettype none

package scroll_pkg;

    // one map cell, attribute byte in the upper half
    typedef struct packed {
        logic [1:0] code_hi;   // tile code bits 9:8
        logic       vflip;
        logic       hflip;
        logic       window;    // priority over sprites
        logic [2:0] palette;
        logic [7:0] code;
    } tile_entry_t;

    // scrolled beam position
    typedef struct packed {
        logic [1:0] pad;       // always zero
        logic [8:0] hs;
        logic [8:0] vs;
    } scan_pos_t;

    typedef struct packed {
        logic [2:0] colour;
        logic [2:0] palette;
        logic       window;
    } pixel_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SLOT,
        RESP
    } axi_state_e;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_SCROLL_X,
        SEL_SCROLL_Y,
        SEL_NONE
    } reg_sel_e;

    localparam logic [12:0] RAM_BASE      = 13'h0000; // 4 KB map window
    localparam logic [12:0] SCROLL_X_ADDR = 13'h1000;
    localparam logic [12:0] SCROLL_Y_ADDR = 13'h1004;

endpackage

`default_nettype wire
